// File: verilog.f
design/stream_pkg.sv
design/dfa_pkg.sv
design/stream_context_store.sv
design/dfa_engine.sv
design/match_tally.sv
design/pop3_match_top.sv
verification/tb_clock_gen.sv
verification/pop3_match_tb.sv

// File: Bender.yml
package:
  name: pop3_match

sources:
  - design/stream_pkg.sv
  - design/dfa_pkg.sv
  - design/stream_context_store.sv
  - design/dfa_engine.sv
  - design/match_tally.sv
  - design/pop3_match_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/pop3_match_tb.sv

// File: verification/pop3_match_tb.sv
`default_nettype none

// Testbench for the PASS matcher: directed packets, then random interleaved streams
module pop3_match_tb
  import stream_pkg::*;
  import dfa_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef char_t char_q_t[$];

  // 214 packets, none longer than about 24 cycles, 4 ns each
  localparam int NUM_PKTS = 214;
  localparam int MAX_PKT_CYCLES = 24;
  localparam int TIMEOUT_NS = NUM_PKTS * MAX_PKT_CYCLES * 4 + 2000;

  logic clk;
  logic rst_n;
  logic load;
  pkt_start_t pkt_start;
  logic char_vld;
  char_t char_in;
  logic eop;
  pkt_end_t pkt_end;
  match_count_t count;
  logic fired;

  // Model context per stream, progress 0 to 4 through PASS
  int model_prog [STREAM_COUNT];
  // Stream has a saved entry in the DUT memory
  bit model_known [STREAM_COUNT];
  logic [31:0] rng = 32'h290b;
  logic exp_fired;
  match_count_t exp_count;
  bit count_due;
  int errors;
  int test_start_errors;
  int tests_ok;
  int tests_bad;

  tb_clock_gen clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  pop3_match_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .pkt_start (pkt_start),
    .char_vld  (char_vld),
    .char_in   (char_in),
    .eop       (eop),
    .pkt_end   (pkt_end),
    .count     (count),
    .fired     (fired)
  );

  // LCG step, result reduced to 0 .. n-1
  function automatic int unsigned next_random(input int unsigned n);
    rng = rng * 32'd1664525 + 32'd1013904223;
    return (rng >> 16) % n;
  endfunction

  // One step through the literal, a P always restarts
  function automatic int advance(input int prog, input char_t c);
    string pat;
    int p;
    pat = "PASS";
    // Completed match behaves like idle for the next byte
    p = (prog == 4) ? 0 : prog;
    if (c == char_t'(pat[0]))
      return 1;
    if (p > 0 && c == char_t'(pat[p]))
      return p + 1;
    return 0;
  endfunction

  // Expected end progress of a packet and whether it held a full match
  function automatic bit ref_packet(input int start_prog, input char_q_t bytes,
                                    output int end_prog);
    bit matched;
    matched = 1'b0;
    end_prog = start_prog;
    foreach (bytes[i])
    begin
      end_prog = advance(end_prog, bytes[i]);
      if (end_prog == 4)
        matched = 1'b1;
    end
    return matched;
  endfunction

  function automatic char_q_t str_bytes(input string s);
    char_q_t q;
    for (int i = 0; i < s.len(); i++)
      q.push_back(char_t'(s[i]));
    return q;
  endfunction

  // Load, two idle cycles, bytes, three idle cycles, eop
  task automatic send_packet(input int sid, input bit new_stream, input bit enable,
                             input char_q_t bytes);
    int end_prog;
    bit matched;
    matched = ref_packet(new_stream ? 0 : model_prog[sid], bytes, end_prog);
    // Memory is written only on an enabled eop
    if (enable)
    begin
      model_prog[sid] = end_prog;
      model_known[sid] = 1'b1;
    end
    @(negedge clk);
    load = 1'b1;
    pkt_start.stream_id = stream_id_t'(sid);
    pkt_start.new_stream = new_stream;
    @(negedge clk);
    load = 1'b0;
    @(negedge clk);
    foreach (bytes[i])
    begin
      @(negedge clk);
      char_vld = 1'b1;
      char_in = bytes[i];
    end
    @(negedge clk);
    char_vld = 1'b0;
    repeat (3) @(negedge clk);
    exp_fired = matched;
    if (enable && matched)
      exp_count = exp_count + 1'b1;
    eop = 1'b1;
    pkt_end.stream_id = stream_id_t'(sid);
    pkt_end.enable = enable;
    @(negedge clk);
    eop = 1'b0;
    // Let the count check run before the next packet
    @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start_errors)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  // Compare: fired just before eop, count one cycle after
  always @(posedge clk)
  begin
    if (count_due)
    begin
      if (count !== exp_count)
      begin
        $display("mismatch at %0t: count %0d, expected %0d", $time, count, exp_count);
        errors++;
      end
      count_due = 1'b0;
    end
    if (rst_n && eop)
    begin
      if (fired !== exp_fired)
      begin
        $display("mismatch at %0t: fired %0b, expected %0b on stream %0d",
                 $time, fired, exp_fired, pkt_end.stream_id);
        errors++;
      end
      count_due = 1'b1;
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: packets still running after %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    int sid;
    bit new_s;
    bit en;
    int len;
    char_q_t bytes;
    load = 1'b0;
    pkt_start = '0;
    char_vld = 1'b0;
    char_in = '0;
    eop = 1'b0;
    pkt_end = '0;
    exp_fired = 1'b0;
    exp_count = '0;
    count_due = 1'b0;
    errors = 0;
    test_start_errors = 0;
    tests_ok = 0;
    tests_bad = 0;
    foreach (model_prog[i])
    begin
      model_prog[i] = 0;
      model_known[i] = 1'b0;
    end
    @(posedge rst_n);
    @(negedge clk);
    if (count !== '0 || fired !== 1'b0)
    begin
      $display("mismatch at %0t: count %0d fired %0b after reset", $time, count, fired);
      errors++;
    end
    finish_test("1 reset");
    send_packet(0, 1'b1, 1'b1, str_bytes("PASS"));
    send_packet(0, 1'b0, 1'b1, str_bytes("XXPAXS"));
    send_packet(0, 1'b0, 1'b1, str_bytes("XPAPASSX"));
    send_packet(0, 1'b0, 1'b1, str_bytes("PASSPASS"));
    finish_test("2 single packet");
    // Enabled first half carries over, disabled or new stream does not
    send_packet(1, 1'b1, 1'b1, str_bytes("PA"));
    send_packet(1, 1'b0, 1'b1, str_bytes("SS"));
    send_packet(2, 1'b1, 1'b1, str_bytes("XX"));
    send_packet(2, 1'b0, 1'b0, str_bytes("PA"));
    send_packet(2, 1'b0, 1'b1, str_bytes("SS"));
    send_packet(3, 1'b1, 1'b1, str_bytes("PA"));
    send_packet(3, 1'b1, 1'b1, str_bytes("SS"));
    finish_test("3 split packets");
    send_packet(4, 1'b1, 1'b1, str_bytes("PAS"));
    send_packet(4, 1'b0, 1'b0, str_bytes("S"));
    send_packet(4, 1'b0, 1'b1, str_bytes("S"));
    finish_test("4 disabled packet");
    for (int n = 0; n < 200; n++)
    begin
      sid = 16 + next_random(8);
      new_s = !model_known[sid] || next_random(16) == 0;
      en = next_random(4) != 0;
      len = 1 + next_random(12);
      bytes.delete();
      for (int i = 0; i < len; i++)
      begin
        case (next_random(4))
          0: bytes.push_back(PAT_P);
          1: bytes.push_back(PAT_A);
          2: bytes.push_back(PAT_S);
          default: bytes.push_back(8'h58);
        endcase
      end
      send_packet(sid, new_s, en, bytes);
    end
    finish_test("5 interleaved streams");
    $display("tests ok: %0d, tests with errors: %0d, total errors: %0d",
             tests_ok, tests_bad, errors);
    if (errors == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

// Free-running 4 ns clock and a synchronous reset held for 10 cycles
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: design/pop3_match_top.sv
`default_nettype none

// POP3 PASS matcher over interleaved packet streams
// Context store -> DFA engine -> match tally
module pop3_match_top
  import stream_pkg::*;
  import dfa_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  // Packet start
  input  wire logic       load,
  input  wire pkt_start_t pkt_start,
  // Payload bytes
  input  wire logic       char_vld,
  input  wire char_t      char_in,
  // Packet end
  input  wire logic       eop,
  input  wire pkt_end_t   pkt_end,
  // Results
  output match_count_t    count,
  output logic            fired
);

  // Store to engine
  wire logic       restore_vld;
  wire dfa_state_t restore_state;

  // Engine to store and tally
  wire dfa_state_t state_out;
  wire logic       accept_out;

  // Saves and restores per-stream state
  stream_context_store store_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .load          (load),
    .pkt_start     (pkt_start),
    .eop           (eop),
    .pkt_end       (pkt_end),
    .state_out     (state_out),
    .restore_vld   (restore_vld),
    .restore_state (restore_state)
  );

  // Pattern automaton
  dfa_engine engine_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_vld      (char_vld),
    .char_in       (char_in),
    .restore_vld   (restore_vld),
    .restore_state (restore_state),
    .state_out     (state_out),
    .accept_out    (accept_out)
  );

  // Only the enable bit of pkt_end matters here
  match_tally tally_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .eop        (eop),
    .enable     (pkt_end.enable),
    .accept_out (accept_out),
    .fired      (fired),
    .count      (count)
  );

endmodule

`default_nettype wire

// File: design/match_tally.sv
`default_nettype none

// Speculative per-packet match flag and the committed packet count
module match_tally
  import stream_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  // Packet framing strobes
  input  wire logic load,
  input  wire logic eop,
  // Matcher enabled for the packet ending now
  input  wire logic enable,
  // Match pulse from the engine
  input  wire logic accept_out,
  // Match seen somewhere in the current packet
  output logic      fired,
  // Packets that matched, committed at end of packet
  output match_count_t count
);

  // Flag as it stands at this edge
  // An accept arriving with eop still counts for this packet
  logic hit;

  assign hit = fired | accept_out;

  // Later assignments take priority
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired <= 1'b0;
    end
    else
    begin
      // New packet, nothing seen yet
      if (load)
      begin
        fired <= 1'b0;
      end
      if (accept_out)
      begin
        fired <= 1'b1;
      end
      // Disabled packet, result is thrown away
      if (eop && !enable)
      begin
        fired <= 1'b0;
      end
    end
  end

  // At most one increment per packet, however many matches it held
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count <= '0;
    end
    else if (eop && enable)
    begin
      count <= count + match_count_t'(hit);
    end
  end

endmodule

`default_nettype wire

// File: design/dfa_engine.sv
`default_nettype none

// Hand-coded DFA for the literal PASS
// Three register stages: input, state, output
module dfa_engine
  import dfa_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  // Byte stream
  input  wire logic       char_vld,
  input  wire char_t      char_in,
  // State override at packet start
  input  wire logic       restore_vld,
  input  wire dfa_state_t restore_state,
  // Registered results
  output dfa_state_t      state_out,
  output logic            accept_out
);

  // Input stage
  logic       char_vld_q;
  char_t      char_q;
  logic       restore_vld_q;
  dfa_state_t restore_state_q;

  // State stage
  dfa_state_t state_q;
  logic       accept_q;

  // Next-state logic
  dfa_state_t from_state;
  dfa_state_t next_state;

  // Input valids carry control, so they reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_q    <= 1'b0;
      restore_vld_q <= 1'b0;
    end
    else
    begin
      char_vld_q    <= char_vld;
      restore_vld_q <= restore_vld;
    end
  end

  // Input payload
  always_ff @(posedge clk)
  begin
    char_q          <= char_in;
    restore_state_q <= restore_state;
  end

  always_comb
  begin
    // After a full match, continue as if from idle so overlaps still count
    from_state = (state_q == st_pass) ? st_idle : state_q;
    if (char_q == PAT_P)
    begin
      // P always restarts the pattern, covers PAPASS style overlap
      next_state = st_p;
    end
    else
    begin
      case (from_state)
        st_p:    next_state = (char_q == PAT_A) ? st_pa : st_idle;
        st_pa:   next_state = (char_q == PAT_S) ? st_pas : st_idle;
        st_pas:  next_state = (char_q == PAT_S) ? st_pass : st_idle;
        default: next_state = st_idle;
      endcase
    end
  end

  // State stage
  // Restore wins over a byte, the sender keeps them apart anyway
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= st_idle;
      accept_q <= 1'b0;
    end
    else if (restore_vld_q)
    begin
      state_q  <= restore_state_q;
      accept_q <= 1'b0;
    end
    else if (char_vld_q)
    begin
      state_q  <= next_state;
      // Accept only on entering st_pass, one pulse per match
      accept_q <= (next_state == st_pass);
    end
    else
    begin
      accept_q <= 1'b0;
    end
  end

  // Output stage, for timing toward store and tally
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out  <= st_idle;
      accept_out <= 1'b0;
    end
    else
    begin
      state_out  <= state_q;
      accept_out <= accept_q;
    end
  end

endmodule

`default_nettype wire

// File: design/stream_context_store.sv
`default_nettype none

// Per-stream DFA context
// Restores the saved state at packet start, saves the final state at end of packet
module stream_context_store
  import stream_pkg::*;
  import dfa_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  // Packet start strobe and its control
  input  wire logic       load,
  input  wire pkt_start_t pkt_start,
  // End-of-packet strobe and its control
  input  wire logic       eop,
  input  wire pkt_end_t   pkt_end,
  // Final state from the engine, stable by the time eop arrives
  input  wire dfa_state_t state_out,
  // Restore request toward the engine, one cycle after load
  output logic            restore_vld,
  output dfa_state_t      restore_state
);

  // One saved state per stream
  // Contents are only meaningful once a stream has been written
  dfa_state_t state_mem [STREAM_COUNT];

  // Save on enabled end of packet
  // A disabled packet leaves the previous context in place
  always_ff @(posedge clk)
  begin
    if (eop && pkt_end.enable)
    begin
      state_mem[pkt_end.stream_id] <= state_out;
    end
  end

  // Restore strobe, single cycle per load
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      restore_vld <= 1'b0;
    end
    else
    begin
      restore_vld <= load;
    end
  end

  // Restore value, only looked at while restore_vld is high
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      // Unknown stream starts clean
      if (pkt_start.new_stream)
      begin
        restore_state <= st_idle;
      end
      else
      begin
        restore_state <= state_mem[pkt_start.stream_id];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/dfa_pkg.sv
`default_nettype none

// Automaton types and pattern constants for the PASS matcher
package dfa_pkg;

  // Input byte width
  localparam int CHAR_W = 8;

  // Encoding width of the automaton state
  localparam int DFA_STATE_W = 3;

  // Depth of the per-stream context memory
  localparam int STREAM_COUNT = 64;

  // One byte of the packet payload
  typedef logic [CHAR_W-1:0] char_t;

  // Pattern bytes, ASCII and case sensitive
  localparam char_t PAT_P = 8'h50;
  localparam char_t PAT_A = 8'h41;
  // S appears twice in the pattern
  localparam char_t PAT_S = 8'h53;

  // Progress through the pattern
  // Also the value kept per stream between packets
  typedef enum logic [DFA_STATE_W-1:0] {
    // Nothing matched yet
    st_idle,
    // Seen P
    st_p,
    // Seen PA
    st_pa,
    // Seen PAS
    st_pas,
    // Full PASS seen, accepting
    st_pass
  } dfa_state_t;

endpackage

`default_nettype wire

// File: design/stream_pkg.sv
`default_nettype none

// Packet control types shared by the sender side and the design
package stream_pkg;

  // Stream id width, enough for 64 interleaved streams
  localparam int STREAM_ID_W = 6;

  // Width of the running count of matching packets
  localparam int COUNT_W = 16;

  // Identifies one of the interleaved streams
  typedef logic [STREAM_ID_W-1:0] stream_id_t;

  // Sent with the load strobe at packet start
  typedef struct packed {
    // Stream the packet belongs to
    stream_id_t stream_id;
    // Stream has no saved context yet, start from idle
    logic       new_stream;
  } pkt_start_t;

  // Sent with the end-of-packet strobe
  typedef struct packed {
    // Stream the packet belongs to
    stream_id_t stream_id;
    // Matcher active for this stream, commit flag and state
    logic       enable;
  } pkt_end_t;

  // Count of packets that contained a match
  typedef logic [COUNT_W-1:0] match_count_t;

endpackage

`default_nettype wire
